//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic restart_i,
  output logic clk_o,
  output logic reset_o
);

  // Rising edges of reset still to go
  logic [3:0] hold_q = 4'd10;

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    forever #4 clk_o = ~clk_o;
  end

  // Reset covers 10 rising edges, at start and after every restart request
  always @(posedge clk_o) begin
    if (restart_i) begin
      hold_q  <= 4'd10;
      reset_o <= 1'b1;
    end else if (hold_q != 4'd0) begin
      hold_q  <= hold_q - 4'd1;
      reset_o <= (hold_q != 4'd1);
    end
  end

endmodule

//--- sim/trace_mon_tb.sv
`timescale 1ns/1ps

module trace_mon_tb
  import trace_mon_pkg::*;
();

  logic                       clk;
  logic                       reset;
  logic                       restart;
  logic [NUM_CORES-1:0]       trace_valid;
  logic [NUM_CORES-1:0][31:0] trace_insn;
  logic [NUM_CORES-1:0]       trace_wben;
  logic [NUM_CORES-1:0][4:0]  trace_wbreg;
  logic [NUM_CORES-1:0][31:0] trace_wbdata;
  logic                       evt_valid;
  logic [CORE_ID_W-1:0]       evt_core;
  evt_kind_e                  evt_kind;
  logic [31:0]                evt_data;
  logic [NUM_CORES-1:0]       overflow;
  logic                       done;

  string                test_name = "none";
  int                   value_errs = 0;
  int                   other_errs = 0;
  logic [31:0]          rng_state = 32'h5a11337e;
  logic [NUM_CORES-1:0] exit_mask;
  logic                 done_seen;

  // Expected events in per-core order, received events in arrival order
  logic [CORE_ID_W-1:0] exp_core [$];
  evt_kind_e            exp_kind [$];
  logic [31:0]          exp_data [$];
  logic [CORE_ID_W-1:0] rx_core [$];
  evt_kind_e            rx_kind [$];
  logic [31:0]          rx_data [$];

  tb_clock_gen u_clock_gen (
    .restart_i (restart),
    .clk_o     (clk),
    .reset_o   (reset)
  );

  trace_mon_top uut (
    .clk            (clk),
    .reset_i        (reset),
    .trace_valid_i  (trace_valid),
    .trace_insn_i   (trace_insn),
    .trace_wben_i   (trace_wben),
    .trace_wbreg_i  (trace_wbreg),
    .trace_wbdata_i (trace_wbdata),
    .evt_valid_o    (evt_valid),
    .evt_core_o     (evt_core),
    .evt_kind_o     (evt_kind),
    .evt_data_o     (evt_data),
    .overflow_o     (overflow),
    .done_o         (done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_kind(input evt_kind_e expected, input evt_kind_e actual);
    if (actual !== expected) begin
      value_errs++;
      $display("ERROR %s: kind expected %0d, actual %0d", test_name, expected, actual);
    end
  endtask

  task automatic check_data(input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      value_errs++;
      $display("ERROR %s: data expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  task automatic check_core(input logic [CORE_ID_W-1:0] expected,
                            input logic [CORE_ID_W-1:0] actual);
    if (actual !== expected) begin
      value_errs++;
      $display("ERROR %s: core expected %0d, actual %0d", test_name, expected, actual);
    end
  endtask

  task automatic check_bit(input string label, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errs++;
      $display("ERROR %s: %s expected %b, actual %b", test_name, label, expected, actual);
    end
  endtask

  task automatic expect_event(input logic [CORE_ID_W-1:0] core, input evt_kind_e kind,
                              input logic [31:0] data);
    exp_core.push_back(core);
    exp_kind.push_back(kind);
    exp_data.push_back(data);
  endtask

  // Index of the oldest expected event of a core, -1 if there is none
  function automatic int head_of(input int core);
    for (int i = 0; i < exp_core.size(); i++) begin
      if (exp_core[i] == core) return i;
    end
    return -1;
  endfunction

  task automatic compare_stream();
    int r;
    int c;
    int h;
    int m;
    for (r = 0; r < rx_core.size(); r++) begin
      m = -1;
      // Match on data against every core's head, the reported core first
      h = head_of(rx_core[r]);
      if (h >= 0 && exp_data[h] == rx_data[r]) m = h;
      for (c = 0; c < NUM_CORES; c++) begin
        h = head_of(c);
        if (m < 0 && h >= 0 && exp_data[h] == rx_data[r]) m = h;
      end
      if (m < 0) m = head_of(rx_core[r]);
      if (m < 0) begin
        other_errs++;
        $display("%s: unexpected event from core %0d with data %h", test_name,
                 rx_core[r], rx_data[r]);
      end else begin
        check_core(exp_core[m], rx_core[r]);
        check_kind(exp_kind[m], rx_kind[r]);
        check_data(exp_data[m], rx_data[r]);
        exp_core.delete(m);
        exp_kind.delete(m);
        exp_data.delete(m);
      end
    end
    for (r = 0; r < exp_core.size(); r++) begin
      other_errs++;
      $display("%s: event of core %0d with data %h never arrived", test_name,
               exp_core[r], exp_data[r]);
    end
    exp_core.delete();
    exp_kind.delete();
    exp_data.delete();
    rx_core.delete();
    rx_kind.delete();
    rx_data.delete();
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    trace_valid  <= '0;
    trace_insn   <= '0;
    trace_wben   <= '0;
    trace_wbreg  <= '0;
    trace_wbdata <= '0;
  endtask

  task automatic restart_dut();
    int n;
    idle_cycle();
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    @(posedge clk);
    n = 0;
    while (reset && n < 40) begin
      @(posedge clk);
      n++;
    end
    if (reset) begin
      other_errs++;
      $display("%s: reset did not end within 40 cycles", test_name);
    end
    exp_core.delete();
    exp_kind.delete();
    exp_data.delete();
    rx_core.delete();
    rx_kind.delete();
    rx_data.delete();
  endtask

  task automatic wait_events();
    int n;
    idle_cycle();
    n = 0;
    while (rx_core.size() < exp_core.size() && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (rx_core.size() < exp_core.size()) begin
      other_errs++;
      $display("%s: timed out waiting for %0d events, %0d arrived", test_name,
               exp_core.size(), rx_core.size());
    end
    // Extra cycles so that events which must not exist get a chance to show up
    repeat (8) @(posedge clk);
    compare_stream();
  endtask

  task automatic check_done(input logic expected);
    int n;
    idle_cycle();
    @(negedge clk);
    n = 0;
    while (expected && !done && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (expected && !done) begin
      other_errs++;
      $display("%s: done_o did not rise within 200 cycles", test_name);
    end else begin
      check_bit("done_o", expected, done);
    end
  endtask

  task automatic check_overflow(input logic [NUM_CORES-1:0] expected);
    idle_cycle();
    @(negedge clk);
    for (int c = 0; c < NUM_CORES; c++) begin
      check_bit($sformatf("overflow_o[%0d]", c), expected[c], overflow[c]);
    end
  endtask

  // One core retires putc every cycle and loads a new r3 in the same retire
  task automatic putc_burst(input int core, input int count);
    logic [31:0] prev;
    idle_cycle();
    rng_state = xorshift32(rng_state);
    prev = rng_state;
    @(posedge clk);
    trace_valid[core]  <= 1'b1;
    trace_insn[core]   <= 32'h9c600000;
    trace_wben[core]   <= 1'b1;
    trace_wbreg[core]  <= 5'd3;
    trace_wbdata[core] <= prev;
    for (int i = 0; i < count; i++) begin
      rng_state = xorshift32(rng_state);
      @(posedge clk);
      trace_insn[core]   <= {NOP_OPC, 8'h00, NOP_PUTC};
      trace_wbdata[core] <= rng_state;
      expect_event(core, EVT_PUTC, prev);
      prev = rng_state;
    end
    idle_cycle();
  endtask

  // All cores retire putc together, the lossy output is drained and dropped
  task automatic flood_putc(input int cycles);
    int quiet;
    int n;
    idle_cycle();
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      trace_valid <= '1;
      trace_insn  <= {NUM_CORES{NOP_OPC, 8'h00, NOP_PUTC}};
    end
    idle_cycle();
    quiet = 0;
    n = 0;
    while (quiet < 8 && n < 200) begin
      @(negedge clk);
      quiet = evt_valid ? 0 : quiet + 1;
      n++;
    end
    if (quiet < 8) begin
      other_errs++;
      $display("%s: event stream did not go quiet within 200 cycles", test_name);
    end
    @(posedge clk);
    rx_core.delete();
    rx_kind.delete();
    rx_data.delete();
  endtask

  // Output monitor, also watches the done level
  always @(negedge clk) begin
    if (reset) begin
      exit_mask = '0;
      done_seen = 1'b0;
    end else begin
      if (done && !done_seen && !(&exit_mask)) begin
        other_errs++;
        $display("%s: done_o rose before every exit event was output", test_name);
      end
      if (done_seen && !done) begin
        other_errs++;
        $display("%s: done_o fell again before reset", test_name);
      end
      done_seen = done_seen || done;
      if (evt_valid) begin
        rx_core.push_back(evt_core);
        rx_kind.push_back(evt_kind);
        rx_data.push_back(evt_data);
        if (evt_kind == EVT_EXIT) exit_mask[evt_core] = 1'b1;
      end
    end
  end

  initial begin
    int                   fd;
    int                   n;
    int                   core;
    int                   count;
    string                line;
    string                cmd;
    string                kind_str;
    logic [NUM_CORES-1:0] vmask;
    logic [NUM_CORES-1:0] wmask;
    logic [31:0]          insn [NUM_CORES];
    logic [4:0]           wbreg [NUM_CORES];
    logic [31:0]          wbdata [NUM_CORES];
    logic [31:0]          value;

    restart      = 1'b0;
    trace_valid  = '0;
    trace_insn   = '0;
    trace_wben   = '0;
    trace_wbreg  = '0;
    trace_wbdata = '0;
    fd = $fopen("sim/trace_mon_testdata.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Cannot open sim/trace_mon_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s", cmd);
        if (n < 1 || cmd.substr(0, 0) == "#") continue;
        if (cmd == "T") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", cmd, vmask, wmask,
                      insn[0], insn[1], insn[2], insn[3], wbreg[0], wbreg[1], wbreg[2],
                      wbreg[3], wbdata[0], wbdata[1], wbdata[2], wbdata[3]);
          if (n != 15) begin
            other_errs++;
            $display("Malformed trace line: %s", line);
          end else begin
            @(posedge clk);
            trace_valid <= vmask;
            trace_wben  <= wmask;
            for (int c = 0; c < NUM_CORES; c++) begin
              trace_insn[c]   <= insn[c];
              trace_wbreg[c]  <= wbreg[c];
              trace_wbdata[c] <= wbdata[c];
            end
          end
        end else if (cmd == "E") begin
          n = $sscanf(line, "%s %d %s %h", cmd, core, kind_str, value);
          if (n == 4 && kind_str == "X") expect_event(core, EVT_EXIT, value);
          else if (n == 4 && kind_str == "R") expect_event(core, EVT_REPORT, value);
          else if (n == 4 && kind_str == "P") expect_event(core, EVT_PUTC, value);
          else begin
            other_errs++;
            $display("Malformed expected event line: %s", line);
          end
        end else if (cmd == "NAME") begin
          n = $sscanf(line, "%s %s", cmd, test_name);
        end else if (cmd == "RST") begin
          restart_dut();
        end else if (cmd == "WAIT") begin
          wait_events();
        end else if (cmd == "DONE" && $sscanf(line, "%s %d", cmd, count) == 2) begin
          check_done(count != 0);
        end else if (cmd == "OVF" && $sscanf(line, "%s %h", cmd, value) == 2) begin
          check_overflow(value[NUM_CORES-1:0]);
        end else if (cmd == "BURST" && $sscanf(line, "%s %d %d", cmd, core, count) == 3) begin
          putc_burst(core, count);
        end else if (cmd == "FLOOD" && $sscanf(line, "%s %d", cmd, count) == 2) begin
          flood_putc(count);
        end else begin
          other_errs++;
          $display("Unknown or malformed command line: %s", line);
        end
      end
      $fclose(fd);
    end
    $display("Checks finished with %0d value errors and %0d other errors",
             value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sim/trace_mon_testdata.txt
# T vmask wmask insn0..insn3 wbreg0..wbreg3 wbdata0..wbdata3, hex, mask bit c is core c
# E core kind data, kind X exit, R report, P putc; other lines are commands
NAME shadow_decode
RST
# r3 writes on cores 0, 2 and 3, an r4 write on core 1
T f f 9c600011 9c80dead 9c600022 9c600033 3 4 3 3 11 dead 22 33
# Reports and a putc, core 2 writes r3 in the same retire
T f 4 15000002 15000002 15000002 15000004 0 0 3 0 0 0 99 0
E 0 R 11
E 1 R 0
E 2 R 22
E 3 P 33
# Plain nop, unknown code, report, non-nop with a report immediate
T f 0 15000000 15000007 15000002 9c000002 0 0 0 0 0 0 0 0
E 2 R 99
WAIT
NAME ordering
T 2 2 0 9c604141 0 0 0 3 0 0 0 4141 0 0
T f 1 15000004 15000004 15000004 15000004 3 0 0 0 55 0 0 0
T f 0 15000004 15000004 15000004 15000004 0 0 0 0 0 0 0 0
E 0 P 11
E 1 P 4141
E 2 P 99
E 3 P 33
E 0 P 55
E 1 P 4141
E 2 P 99
E 3 P 33
WAIT
DONE 0
NAME exit
T 1 0 15000001 0 0 0 0 0 0 0 0 0 0 0
E 0 X 55
# Core 0 reports after its exit
T 7 0 15000002 15000001 15000001 0 0 0 0 0 0 0 0 0
E 1 X 4141
E 2 X 99
WAIT
DONE 0
T c 0 0 0 15000004 15000002 0 0 0 0 0 0 0 0
E 3 R 33
T 9 0 15000004 0 0 15000001 0 0 0 0 0 0 0 0
E 3 X 33
# Core 3 still writes r3 after exit, its putc is dropped
T 8 8 0 0 0 15000004 0 0 0 3 0 0 0 77
WAIT
DONE 1
DONE 1
NAME putc_burst
RST
BURST 2 24
WAIT
OVF 0
NAME overflow
RST
FLOOD 20
OVF f
DONE 0

//--- src.f
verilog/trace_mon_pkg.sv
verilog/r3_shadow.sv
verilog/nop_event_decoder.sv
verilog/event_fifo.sv
verilog/core_trace_monitor.sv
verilog/event_collector.sv
verilog/trace_mon_top.sv
sim/tb_clock_gen.sv
sim/trace_mon_tb.sv

//--- verilog/core_trace_monitor.sv
`timescale 1ns/1ps

module core_trace_monitor
  import trace_mon_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        trace_valid_i,
  input  logic [31:0] trace_insn_i,
  input  logic        trace_wben_i,
  input  logic [4:0]  trace_wbreg_i,
  input  logic [31:0] trace_wbdata_i,
  input  logic        pop_i,
  output logic        empty_o,
  output evt_kind_e   head_kind_o,
  output logic [31:0] head_data_o,
  output logic        overflow_o
);

  logic [31:0] r3;
  logic        push;
  evt_kind_e   push_kind;
  logic [31:0] push_data;

  r3_shadow u_r3_shadow (
    .clk      (clk),
    .reset_i  (reset_i),
    .retire_i (trace_valid_i),
    .wben_i   (trace_wben_i),
    .wbreg_i  (trace_wbreg_i),
    .wbdata_i (trace_wbdata_i),
    .r3_o     (r3)
  );

  nop_event_decoder u_decoder (
    .clk         (clk),
    .reset_i     (reset_i),
    .retire_i    (trace_valid_i),
    .insn_i      (trace_insn_i),
    .r3_i        (r3),
    .push_o      (push),
    .push_kind_o (push_kind),
    .push_data_o (push_data)
  );

  event_fifo u_fifo (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_i      (push),
    .push_kind_i (push_kind),
    .push_data_i (push_data),
    .pop_i       (pop_i),
    .empty_o     (empty_o),
    .head_kind_o (head_kind_o),
    .head_data_o (head_data_o),
    .overflow_o  (overflow_o)
  );

endmodule

//--- verilog/event_collector.sv
`timescale 1ns/1ps

module event_collector
  import trace_mon_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic [NUM_CORES-1:0]                empty_i,
  input  evt_kind_e [NUM_CORES-1:0]           head_kind_i,
  input  logic [NUM_CORES-1:0][31:0]          head_data_i,
  output logic [NUM_CORES-1:0]                pop_o,
  output logic                                evt_valid_o,
  output logic [CORE_ID_W-1:0]                evt_core_o,
  output evt_kind_e                           evt_kind_o,
  output logic [31:0]                         evt_data_o,
  output logic                                done_o
);

  logic [CORE_ID_W-1:0] last_q;
  logic [CORE_ID_W-1:0] cand;
  logic [CORE_ID_W-1:0] grant_idx;
  logic                 grant_valid;
  logic                 evt_valid_q;
  logic [CORE_ID_W-1:0] evt_core_q;
  evt_kind_e            evt_kind_q;
  logic [31:0]          evt_data_q;
  logic [NUM_CORES-1:0] exited_q;
  logic [NUM_CORES-1:0] exited_next;
  coll_state_e          state_q;

  // Search starts at the core after the one served last
  always_comb begin
    grant_valid = 1'b0;
    grant_idx   = last_q;
    cand        = last_q;
    pop_o       = '0;
    for (int off = 1; off <= NUM_CORES; off++) begin
      cand = last_q + CORE_ID_W'(off);
      if (!grant_valid && !empty_i[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
    pop_o[grant_idx] = grant_valid;
  end

  // Exit bookkeeping is done on the delivered event
  always_comb begin
    exited_next = exited_q;
    if (evt_valid_q && (evt_kind_q == EVT_EXIT)) begin
      exited_next[evt_core_q] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      last_q      <= '0;
      evt_valid_q <= 1'b0;
      exited_q    <= '0;
      state_q     <= COLL_RUN;
    end else begin
      evt_valid_q <= grant_valid;
      if (grant_valid) last_q <= grant_idx;
      exited_q <= exited_next;
      // Queues keep draining after done
      if (state_q == COLL_RUN && (&exited_next)) begin
        state_q <= COLL_DONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_valid) begin
      evt_core_q <= grant_idx;
      evt_kind_q <= head_kind_i[grant_idx];
      evt_data_q <= head_data_i[grant_idx];
    end
  end

  assign evt_valid_o = evt_valid_q;
  assign evt_core_o  = evt_core_q;
  assign evt_kind_o  = evt_kind_q;
  assign evt_data_o  = evt_data_q;
  assign done_o      = (state_q == COLL_DONE);

endmodule

//--- verilog/event_fifo.sv
`timescale 1ns/1ps

module event_fifo
  import trace_mon_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        push_i,
  input  evt_kind_e   push_kind_i,
  input  logic [31:0] push_data_i,
  input  logic        pop_i,
  output logic        empty_o,
  output evt_kind_e   head_kind_o,
  output logic [31:0] head_data_o,
  output logic        overflow_o
);

  evt_kind_e             kind_mem [EVT_DEPTH];
  logic [31:0]           data_mem [EVT_DEPTH];
  logic [EVT_PTR_W-1:0]  rd_ptr_q;
  logic [EVT_PTR_W-1:0]  wr_ptr_q;
  logic [EVT_PTR_W:0]    count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;
  logic                  overflow_q;

  assign full    = (count_q == (EVT_PTR_W + 1)'(EVT_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_pop  = pop_i && !empty_o;
  // A slot freed by a pop in the same cycle can take the push
  assign do_push = push_i && (!full || do_pop);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (EVT_PTR_W + 1)'(do_push) - (EVT_PTR_W + 1)'(do_pop);
      if (push_i && !do_push) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      kind_mem[wr_ptr_q] <= push_kind_i;
      data_mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_kind_o = kind_mem[rd_ptr_q];
  assign head_data_o = data_mem[rd_ptr_q];
  assign overflow_o  = overflow_q;

endmodule

//--- verilog/nop_event_decoder.sv
`timescale 1ns/1ps

module nop_event_decoder
  import trace_mon_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        retire_i,
  input  logic [31:0] insn_i,
  input  logic [31:0] r3_i,
  output logic        push_o,
  output evt_kind_e   push_kind_o,
  output logic [31:0] push_data_o
);

  nop_code_e   imm;
  logic        is_nop;
  logic        known;
  evt_kind_e   kind;
  logic        hit;
  logic        push_q;
  evt_kind_e   kind_q;
  logic [31:0] data_q;
  logic        exited_q;

  assign is_nop = (insn_i[31:24] == NOP_OPC);
  assign imm    = nop_code_e'(insn_i[15:0]);

  // Map the immediate to an event kind, NOP_NOP and unknown codes are silent
  always_comb begin
    known = 1'b1;
    kind  = EVT_PUTC;
    case (imm)
      NOP_EXIT:   kind = EVT_EXIT;
      NOP_REPORT: kind = EVT_REPORT;
      NOP_PUTC:   kind = EVT_PUTC;
      default:    known = 1'b0;
    endcase
  end

  // Nothing is reported once the core has exited
  assign hit = retire_i && is_nop && known && !exited_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      push_q   <= 1'b0;
      exited_q <= 1'b0;
    end else begin
      push_q <= hit;
      if (hit && (kind == EVT_EXIT)) begin
        exited_q <= 1'b1;
      end
    end
  end

  // Event payload
  always_ff @(posedge clk) begin
    if (hit) begin
      kind_q <= kind;
      data_q <= r3_i;
    end
  end

  assign push_o      = push_q;
  assign push_kind_o = kind_q;
  assign push_data_o = data_q;

endmodule

//--- verilog/r3_shadow.sv
`timescale 1ns/1ps

module r3_shadow
  import trace_mon_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        retire_i,
  input  logic        wben_i,
  input  logic [4:0]  wbreg_i,
  input  logic [31:0] wbdata_i,
  output logic [31:0] r3_o
);

  logic [31:0] r3_q;
  logic        r3_write;

  // Only retired write-backs to r3 update the copy
  assign r3_write = retire_i && wben_i && (wbreg_i == R3_REG);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      r3_q <= '0;
    end else if (r3_write) begin
      r3_q <= wbdata_i;
    end
  end

  // Registered, so a write in the current cycle is not yet visible
  assign r3_o = r3_q;

endmodule

//--- verilog/trace_mon_pkg.sv
package trace_mon_pkg;

  // Number of traced cores and width of a core number
  localparam int NUM_CORES = 4;
  localparam int CORE_ID_W = 2;

  // Per-core event queue
  localparam int EVT_DEPTH = 4;
  localparam int EVT_PTR_W = $clog2(EVT_DEPTH);

  // Register that carries the l.nop argument
  localparam logic [4:0] R3_REG = 5'd3;

  // Major opcode of l.nop, bits 31:24 of the instruction
  localparam logic [7:0] NOP_OPC = 8'h15;

  // Immediate of l.nop selects the simulation service
  typedef enum logic [15:0] {
    NOP_NOP    = 16'h0000,
    NOP_EXIT   = 16'h0001,
    NOP_REPORT = 16'h0002,
    NOP_PUTC   = 16'h0004
  } nop_code_e;

  // Kind of event handed to the collector
  typedef enum logic [1:0] {
    EVT_EXIT   = 2'd0,
    EVT_REPORT = 2'd1,
    EVT_PUTC   = 2'd2
  } evt_kind_e;

  // Collector termination state
  typedef enum logic {
    COLL_RUN  = 1'b0,
    COLL_DONE = 1'b1
  } coll_state_e;

endpackage

//--- verilog/trace_mon_top.sv
`timescale 1ns/1ps

module trace_mon_top
  import trace_mon_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic [NUM_CORES-1:0]        trace_valid_i,
  input  logic [NUM_CORES-1:0][31:0]  trace_insn_i,
  input  logic [NUM_CORES-1:0]        trace_wben_i,
  input  logic [NUM_CORES-1:0][4:0]   trace_wbreg_i,
  input  logic [NUM_CORES-1:0][31:0]  trace_wbdata_i,
  output logic                        evt_valid_o,
  output logic [CORE_ID_W-1:0]        evt_core_o,
  output evt_kind_e                   evt_kind_o,
  output logic [31:0]                 evt_data_o,
  output logic [NUM_CORES-1:0]        overflow_o,
  output logic                        done_o
);

  logic [NUM_CORES-1:0]       pop;
  logic [NUM_CORES-1:0]       empty;
  evt_kind_e [NUM_CORES-1:0]  head_kind;
  logic [NUM_CORES-1:0][31:0] head_data;

  // One monitor per traced core
  for (genvar c = 0; c < NUM_CORES; c++) begin : gen_core_mon
    core_trace_monitor u_core_mon (
      .clk            (clk),
      .reset_i        (reset_i),
      .trace_valid_i  (trace_valid_i[c]),
      .trace_insn_i   (trace_insn_i[c]),
      .trace_wben_i   (trace_wben_i[c]),
      .trace_wbreg_i  (trace_wbreg_i[c]),
      .trace_wbdata_i (trace_wbdata_i[c]),
      .pop_i          (pop[c]),
      .empty_o        (empty[c]),
      .head_kind_o    (head_kind[c]),
      .head_data_o    (head_data[c]),
      .overflow_o     (overflow_o[c])
    );
  end

  event_collector u_collector (
    .clk         (clk),
    .reset_i     (reset_i),
    .empty_i     (empty),
    .head_kind_i (head_kind),
    .head_data_i (head_data),
    .pop_o       (pop),
    .evt_valid_o (evt_valid_o),
    .evt_core_o  (evt_core_o),
    .evt_kind_o  (evt_kind_o),
    .evt_data_o  (evt_data_o),
    .done_o      (done_o)
  );

endmodule
